// ==== hw/ex_alu.sv ====
module ex_alu (
    input  rv_isa_pkg::opcode_t opcode,
    input  rv_isa_pkg::alu_op_t alu_op,
    input  rv_pipe_pkg::data_t  rs1_data,
    input  rv_pipe_pkg::data_t  rs2_data,
    input  rv_pipe_pkg::data_t  imm,
    input  rv_pipe_pkg::pc_t    pc,
    output rv_pipe_pkg::data_t  alu_value
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    data_t      op_a;
    data_t      op_b;
    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       eq;

    // Operand selection
    always_comb begin
        if (opcode == OP_JAL || opcode == OP_AUIPC) begin
            op_a = pc;
        end else begin
            op_a = rs1_data;
        end
        if (opcode == OP_RTYPE || opcode == OP_BRANCH) begin
            op_b = rs2_data;
        end else begin
            op_b = imm;
        end
    end

    assign shamt = op_b[4:0];
    assign lt_s  = $signed(op_a) < $signed(op_b);
    assign lt_u  = op_a < op_b;
    assign eq    = op_a == op_b;

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_value = op_a + op_b;
            ALU_SUB:  alu_value = op_a - op_b;
            ALU_SLT:  alu_value = {31'b0, lt_s};
            ALU_SLTU: alu_value = {31'b0, lt_u};
            ALU_XOR:  alu_value = op_a ^ op_b;
            ALU_OR:   alu_value = op_a | op_b;
            ALU_AND:  alu_value = op_a & op_b;
            ALU_SLL:  alu_value = op_a << shamt;
            ALU_SRL:  alu_value = op_a >> shamt;
            ALU_SRA:  alu_value = $signed(op_a) >>> shamt;
            // Compares feed the branch decision
            ALU_EQ:   alu_value = {31'b0, eq};
            ALU_NEQ:  alu_value = {31'b0, !eq};
            ALU_GE:   alu_value = {31'b0, !lt_s};
            ALU_GEU:  alu_value = {31'b0, !lt_u};
            default:  alu_value = '0;
        endcase
    end

endmodule

// ==== hw/ex_stage_reg.sv ====
module ex_stage_reg (
    input                          ex_clk,
    input                          ex_rst,
    input  rv_isa_pkg::opcode_t    opcode,
    input  rv_pipe_pkg::funct3_t   funct3,
    input  rv_pipe_pkg::reg_addr_t rd_addr,
    input  rv_pipe_pkg::data_t     rs2_data,
    input  rv_pipe_pkg::data_t     alu_value,
    input  rv_pipe_pkg::pc_t       target_pc,
    input  rv_pipe_pkg::data_t     link_value,
    input  rv_pipe_pkg::data_t     upper_value,
    input                          ce,
    input                          stall,
    input                          flush,
    output rv_isa_pkg::opcode_t    out_opcode,
    output rv_pipe_pkg::funct3_t   out_funct3,
    output rv_pipe_pkg::reg_addr_t out_rd_addr,
    output rv_pipe_pkg::data_t     out_rs2_data,
    output rv_pipe_pkg::data_t     out_rd_data,
    output logic                   out_we_reg,
    output logic                   out_valid,
    output logic                   out_ce,
    output logic                   change_pc,
    output rv_pipe_pkg::pc_t       next_pc,
    output logic                   flush_out,
    output logic                   stall_out
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic  accept;
    logic  is_mem;
    logic  writes;
    logic  redirect;
    data_t rd_value;

    // Own bubble blocks the next op as well
    assign accept = ce && !stall && !stall_out && !flush;
    assign is_mem = (opcode == OP_LOAD) || (opcode == OP_STORE);

    // Write value and redirect by opcode class
    always_comb begin
        rd_value = alu_value;
        writes   = 1'b0;
        redirect = 1'b0;
        case (opcode)
            OP_RTYPE, OP_ITYPE: begin
                writes = 1'b1;
            end
            OP_JAL, OP_JALR: begin
                rd_value = link_value;
                writes   = 1'b1;
                redirect = 1'b1;
            end
            OP_LUI, OP_AUIPC: begin
                rd_value = upper_value;
                writes   = 1'b1;
            end
            OP_BRANCH: begin
                redirect = alu_value[0];
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge ex_clk or negedge ex_rst) begin
        if (!ex_rst) begin
            out_opcode   <= '0;
            out_funct3   <= '0;
            out_rd_addr  <= '0;
            out_rs2_data <= '0;
            out_rd_data  <= '0;
            next_pc      <= '0;
            out_we_reg   <= 1'b0;
            out_valid    <= 1'b0;
            out_ce       <= 1'b0;
            change_pc    <= 1'b0;
            flush_out    <= 1'b0;
            stall_out    <= 1'b0;
        end else begin
            // Single-cycle pulses
            out_we_reg <= 1'b0;
            out_valid  <= 1'b0;
            change_pc  <= 1'b0;
            flush_out  <= 1'b0;
            stall_out  <= 1'b0;
            out_ce     <= accept;
            if (accept) begin
                out_opcode   <= opcode;
                out_funct3   <= funct3;
                out_rd_addr  <= rd_addr;
                out_rs2_data <= rs2_data;
                out_rd_data  <= rd_value;
                out_valid    <= 1'b1;
                out_we_reg   <= writes;
                change_pc    <= redirect;
                flush_out    <= redirect;
                stall_out    <= is_mem;
                if (redirect) begin
                    next_pc <= target_pc;
                end
            end
        end
    end

endmodule

// ==== hw/ex_transfer_unit.sv ====
module ex_transfer_unit (
    input  rv_isa_pkg::opcode_t opcode,
    input  rv_pipe_pkg::data_t  rs1_data,
    input  rv_pipe_pkg::data_t  imm,
    input  rv_pipe_pkg::pc_t    pc,
    output rv_pipe_pkg::pc_t    target_pc,
    output rv_pipe_pkg::data_t  link_value,
    output rv_pipe_pkg::data_t  upper_value
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    pc_t   rel_target;
    data_t reg_sum;
    pc_t   reg_target;

    // pc-relative target, also the AUIPC result
    assign rel_target = pc + imm;

    // JALR drops bit 0 of the register sum
    assign reg_sum    = rs1_data + imm;
    assign reg_target = {reg_sum[31:1], 1'b0};

    always_comb begin
        if (opcode == OP_JALR) begin
            target_pc = reg_target;
        end else begin
            target_pc = rel_target;
        end
    end

    // Return address for JAL/JALR
    assign link_value = pc + PC_STEP;

    always_comb begin
        if (opcode == OP_LUI) begin
            upper_value = {imm[31:12], 12'h000};
        end else begin
            upper_value = rel_target;
        end
    end

endmodule

// ==== hw/rv_execute.sv ====
module rv_execute (
    input                          ex_clk,
    input                          ex_rst,
    input  rv_isa_pkg::opcode_t    opcode,
    input  rv_isa_pkg::alu_op_t    alu_op,
    input  rv_pipe_pkg::funct3_t   funct3,
    // Source indices unused without forwarding
    input  rv_pipe_pkg::reg_addr_t rs1_addr,
    input  rv_pipe_pkg::reg_addr_t rs2_addr,
    input  rv_pipe_pkg::reg_addr_t rd_addr,
    input  rv_pipe_pkg::data_t     rs1_data,
    input  rv_pipe_pkg::data_t     rs2_data,
    input  rv_pipe_pkg::data_t     imm,
    input  rv_pipe_pkg::pc_t       pc,
    input                          ce,
    input                          stall,
    input                          flush,
    output rv_isa_pkg::opcode_t    out_opcode,
    output rv_pipe_pkg::funct3_t   out_funct3,
    output rv_pipe_pkg::reg_addr_t out_rd_addr,
    output rv_pipe_pkg::data_t     out_rs2_data,
    output rv_pipe_pkg::data_t     out_rd_data,
    output logic                   out_we_reg,
    output logic                   out_valid,
    output logic                   out_ce,
    output logic                   change_pc,
    output rv_pipe_pkg::pc_t       next_pc,
    output logic                   flush_out,
    output logic                   stall_out
);
    import rv_pipe_pkg::*;

    data_t alu_value;
    pc_t   target_pc;
    data_t link_value;
    data_t upper_value;

    ex_alu i_alu (
        .opcode    (opcode),
        .alu_op    (alu_op),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .imm       (imm),
        .pc        (pc),
        .alu_value (alu_value)
    );

    ex_transfer_unit i_transfer (
        .opcode      (opcode),
        .rs1_data    (rs1_data),
        .imm         (imm),
        .pc          (pc),
        .target_pc   (target_pc),
        .link_value  (link_value),
        .upper_value (upper_value)
    );

    ex_stage_reg i_stage_reg (
        .ex_clk       (ex_clk),
        .ex_rst       (ex_rst),
        .opcode       (opcode),
        .funct3       (funct3),
        .rd_addr      (rd_addr),
        .rs2_data     (rs2_data),
        .alu_value    (alu_value),
        .target_pc    (target_pc),
        .link_value   (link_value),
        .upper_value  (upper_value),
        .ce           (ce),
        .stall        (stall),
        .flush        (flush),
        .out_opcode   (out_opcode),
        .out_funct3   (out_funct3),
        .out_rd_addr  (out_rd_addr),
        .out_rs2_data (out_rs2_data),
        .out_rd_data  (out_rd_data),
        .out_we_reg   (out_we_reg),
        .out_valid    (out_valid),
        .out_ce       (out_ce),
        .change_pc    (change_pc),
        .next_pc      (next_pc),
        .flush_out    (flush_out),
        .stall_out    (stall_out)
    );

endmodule

// ==== hw/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Opcode class as delivered by decode
    typedef logic [3:0] opcode_t;

    // ALU function select
    typedef logic [3:0] alu_op_t;

    localparam opcode_t OP_NONE   = 4'd0;
    localparam opcode_t OP_RTYPE  = 4'd1;
    localparam opcode_t OP_ITYPE  = 4'd2;
    localparam opcode_t OP_LOAD   = 4'd3;
    localparam opcode_t OP_STORE  = 4'd4;
    localparam opcode_t OP_BRANCH = 4'd5;
    localparam opcode_t OP_JAL    = 4'd6;
    localparam opcode_t OP_JALR   = 4'd7;
    localparam opcode_t OP_LUI    = 4'd8;
    localparam opcode_t OP_AUIPC  = 4'd9;
    localparam opcode_t OP_SYSTEM = 4'd10;
    localparam opcode_t OP_FENCE  = 4'd11;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLT  = 4'd2;
    localparam alu_op_t ALU_SLTU = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_OR   = 4'd5;
    localparam alu_op_t ALU_AND  = 4'd6;
    localparam alu_op_t ALU_SLL  = 4'd7;
    localparam alu_op_t ALU_SRL  = 4'd8;
    localparam alu_op_t ALU_SRA  = 4'd9;
    // Branch compares, result in bit 0
    localparam alu_op_t ALU_EQ   = 4'd10;
    localparam alu_op_t ALU_NEQ  = 4'd11;
    localparam alu_op_t ALU_GE   = 4'd12;
    localparam alu_op_t ALU_GEU  = 4'd13;

endpackage

// ==== hw/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

    // Operand and result word
    typedef logic [31:0] data_t;

    // Instruction address
    typedef logic [31:0] pc_t;

    // Register file index
    typedef logic [4:0] reg_addr_t;

    // funct3 field, passed on for load/store width
    typedef logic [2:0] funct3_t;

    // Link increment, one instruction
    localparam pc_t PC_STEP = 32'd4;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute-stage testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing -f tb.f --top-module tb_rv_execute -o tb_rv_execute > sim.log 2>&1 \
    && ./obj_dir/tb_rv_execute >> sim.log 2>&1 \
    || echo "Build or simulation exited with an error" >> sim.log

if grep -q "^Simulation completed successfully$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see sim.log"
    exit 1
fi

// ==== sim/ex_vectors.txt ====
# ce stall flush opcode alu_op funct3 rd rs1 rs2 imm pc | expected one cycle later:
# out_valid out_we_reg change_pc stall_out out_rd_data next_pc
1 0 0 1 0 0 01 00000005 00000007 00000000 00001000 1 1 0 0 0000000c 00000000
1 0 0 1 1 0 02 00000003 00000005 00000000 00001004 1 1 0 0 fffffffe 00000000
1 0 0 1 2 2 03 ffffffff 00000001 00000000 00001008 1 1 0 0 00000001 00000000
1 0 0 1 3 3 04 ffffffff 00000001 00000000 0000100c 1 1 0 0 00000000 00000000
1 0 0 2 4 4 05 f0f0f0f0 00000000 0ff00ff0 00001010 1 1 0 0 ff00ff00 00000000
1 0 0 2 5 6 06 12340000 00000000 00005678 00001014 1 1 0 0 12345678 00000000
1 0 0 1 6 7 07 ffff0000 0f0f0f0f 00000000 00001018 1 1 0 0 0f0f0000 00000000
1 0 0 1 7 1 08 00000001 0000001f 00000000 0000101c 1 1 0 0 80000000 00000000
1 0 0 2 8 5 09 80000000 00000000 00000024 00001020 1 1 0 0 08000000 00000000
1 0 0 2 9 5 0a 80000000 00000000 00000004 00001024 1 1 0 0 f8000000 00000000
1 0 0 1 2 2 0b 7fffffff 80000000 00000000 00001028 1 1 0 0 00000000 00000000
1 0 0 1 3 3 0c 7fffffff 80000000 00000000 0000102c 1 1 0 0 00000001 00000000
1 0 0 2 0 0 0d 00000010 00000000 fffffff0 00001030 1 1 0 0 00000000 00000000
1 0 0 5 a 0 00 00000042 00000042 00000100 00002000 1 0 1 0 00000000 00002100
1 0 0 5 b 1 00 00000005 00000005 00000010 00002004 1 0 0 0 00000000 00000000
1 0 0 5 b 1 00 00000005 00000006 fffffff0 00002008 1 0 1 0 00000000 00001ff8
1 0 0 5 c 5 00 00000000 ffffffff 00000020 0000200c 1 0 1 0 00000000 0000202c
1 0 0 5 d 7 00 00000000 ffffffff 00000040 00002010 1 0 0 0 00000000 00000000
1 0 0 5 2 4 00 fffffffe 00000001 00000008 00002014 1 0 1 0 00000000 0000201c
1 0 0 6 0 0 01 00000000 00000000 00000400 00003000 1 1 1 0 00003004 00003400
1 0 0 7 0 0 02 00004001 00000000 00000010 00003004 1 1 1 0 00003008 00004010
1 0 0 8 0 0 03 00000000 00000000 12345abc 00003008 1 1 0 0 12345000 00000000
1 0 0 9 0 0 04 00000000 00000000 00001000 0000300c 1 1 0 0 0000400c 00000000
1 0 0 3 0 2 05 00000100 00000000 00000004 00003010 1 0 0 1 00000000 00000000
1 0 0 1 0 0 06 00000001 00000001 00000000 00003014 0 0 0 0 00000000 00000000
1 0 0 4 0 2 00 00000200 deadbeef 00000008 00003018 1 0 0 1 00000000 00000000
1 0 0 2 0 0 07 00000003 00000000 00000004 0000301c 0 0 0 0 00000000 00000000
1 0 1 1 0 0 08 00000001 00000002 00000000 00003020 0 0 0 0 00000000 00000000
1 1 0 1 0 0 08 00000001 00000002 00000000 00003024 0 0 0 0 00000000 00000000
0 0 0 6 0 0 01 00000000 00000000 00000400 00003028 0 0 0 0 00000000 00000000
1 0 1 5 a 0 00 00000007 00000007 00000100 0000302c 0 0 0 0 00000000 00000000
1 0 0 1 4 0 09 0000ffff 00ff00ff 00000000 00003030 1 1 0 0 00ffff00 00000000

// ==== sim/tb_rv_execute.sv ====
module tb_rv_execute;
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    localparam int RESET_TIMEOUT = 20;
    localparam int MAX_LINES     = 200;

    logic      ex_clk;
    logic      ex_rst;
    opcode_t   opcode;
    alu_op_t   alu_op;
    funct3_t   funct3;
    reg_addr_t rs1_addr, rs2_addr, rd_addr;
    data_t     rs1_data, rs2_data, imm;
    pc_t       pc;
    logic      ce, stall, flush;

    opcode_t   out_opcode;
    funct3_t   out_funct3;
    reg_addr_t out_rd_addr;
    data_t     out_rs2_data, out_rd_data;
    pc_t       next_pc;
    logic      out_we_reg, out_valid, out_ce, change_pc, flush_out, stall_out;

    // Fields of the vector line just read
    logic      f_ce, f_stall, f_flush, f_valid, f_we, f_chg, f_stall_out;
    opcode_t   f_opcode;
    alu_op_t   f_alu_op;
    funct3_t   f_funct3;
    reg_addr_t f_rd;
    data_t     f_rs1, f_rs2, f_imm, f_rd_data;
    pc_t       f_pc, f_next_pc;

    // Expected results of the operation driven one cycle earlier
    logic      exp_valid, exp_we, exp_chg, exp_stall, have_exp;
    opcode_t   exp_opcode;
    funct3_t   exp_funct3;
    reg_addr_t exp_rd_addr;
    data_t     exp_rs2_data, exp_rd_data;
    pc_t       exp_next_pc;

    integer errors, fd, n, lines, vectors, waited;
    string  line;
    logic   aborted;

    rv_execute i_dut (.*);

    initial ex_clk = 1'b0;
    always #50 ex_clk = ~ex_clk;

    initial begin
        ex_rst = 1'b0;
        repeat (8) @(posedge ex_clk);
        #5;
        ex_rst = 1'b1;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            errors = errors + 1;
            $display("CHECK FAILED at %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic drive_idle();
        ce       = 1'b0;
        stall    = 1'b0;
        flush    = 1'b0;
        opcode   = OP_NONE;
        alu_op   = ALU_ADD;
        funct3   = '0;
        rd_addr  = '0;
        rs1_data = '0;
        rs2_data = '0;
        imm      = '0;
        pc       = '0;
    endtask

    task automatic apply_fields();
        ce       = f_ce;
        stall    = f_stall;
        flush    = f_flush;
        opcode   = f_opcode;
        alu_op   = f_alu_op;
        funct3   = f_funct3;
        rd_addr  = f_rd;
        rs1_data = f_rs1;
        rs2_data = f_rs2;
        imm      = f_imm;
        pc       = f_pc;
    endtask

    task automatic take_expected();
        exp_valid    = f_valid;
        exp_we       = f_we;
        exp_chg      = f_chg;
        exp_stall    = f_stall_out;
        exp_rd_data  = f_rd_data;
        exp_next_pc  = f_next_pc;
        exp_opcode   = f_opcode;
        exp_funct3   = f_funct3;
        exp_rd_addr  = f_rd;
        exp_rs2_data = f_rs2;
        have_exp     = 1'b1;
    endtask

    task automatic check_outputs();
        check("out_valid", 32'(exp_valid), 32'(out_valid));
        check("out_ce", 32'(exp_valid), 32'(out_ce));
        check("out_we_reg", 32'(exp_we), 32'(out_we_reg));
        check("change_pc", 32'(exp_chg), 32'(change_pc));
        check("flush_out", 32'(exp_chg), 32'(flush_out));
        check("stall_out", 32'(exp_stall), 32'(stall_out));
        if (exp_we) check("out_rd_data", exp_rd_data, out_rd_data);
        if (exp_chg) check("next_pc", exp_next_pc, next_pc);
        // Pass-through fields only move on accepted ops
        if (exp_valid) begin
            check("out_opcode", 32'(exp_opcode), 32'(out_opcode));
            check("out_funct3", 32'(exp_funct3), 32'(out_funct3));
            check("out_rd_addr", 32'(exp_rd_addr), 32'(out_rd_addr));
            check("out_rs2_data", exp_rs2_data, out_rs2_data);
        end
    endtask

    initial begin
        errors   = 0;
        lines    = 0;
        vectors  = 0;
        waited   = 0;
        aborted  = 1'b0;
        have_exp = 1'b0;
        rs1_addr = '0;
        rs2_addr = '0;
        drive_idle();
        fd = $fopen("sim/ex_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file sim/ex_vectors.txt");
            aborted = 1'b1;
        end
        if (!aborted) begin
            // Reset is still held here
            @(posedge ex_clk);
            #5;
            check("control outputs after reset", 32'h0,
                  32'({out_valid, out_we_reg, out_ce, change_pc, flush_out, stall_out}));
            check("out_rd_data after reset", 32'h0, out_rd_data);
            check("next_pc after reset", 32'h0, next_pc);
            check("pass-through fields after reset", 32'h0,
                  32'({out_opcode, out_funct3, out_rd_addr}));
            check("out_rs2_data after reset", 32'h0, out_rs2_data);
        end
        while (!aborted && ex_rst !== 1'b1) begin
            @(posedge ex_clk);
            waited = waited + 1;
            if (waited > RESET_TIMEOUT) begin
                $display("Timed out waiting for reset release after %0d cycles", waited);
                aborted = 1'b1;
            end
        end
        while (!aborted && !$feof(fd)) begin
            lines = lines + 1;
            if (lines > MAX_LINES) begin
                $display("Timed out reading vectors, no end of file after %0d lines", MAX_LINES);
                aborted = 1'b1;
            end else begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                f_ce, f_stall, f_flush, f_opcode, f_alu_op, f_funct3, f_rd,
                                f_rs1, f_rs2, f_imm, f_pc, f_valid, f_we, f_chg,
                                f_stall_out, f_rd_data, f_next_pc);
                end
                if (n == 17) begin
                    @(posedge ex_clk);
                    #5;
                    apply_fields();
                    // Sample just before the next edge
                    #90;
                    if (have_exp) check_outputs();
                    take_expected();
                    vectors = vectors + 1;
                end
            end
        end
        if (!aborted && have_exp) begin
            @(posedge ex_clk);
            #5;
            drive_idle();
            #90;
            check_outputs();
        end
        if (!aborted && vectors == 0) begin
            $display("The vector file held no usable vectors");
            aborted = 1'b1;
        end
        if (fd != 0) $fclose(fd);
        $display("Vectors: %0d  Errors: %0d", vectors, errors);
        if (errors == 0 && !aborted) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/ex_alu.sv
hw/ex_transfer_unit.sv
hw/ex_stage_reg.sv
hw/rv_execute.sv
sim/tb_rv_execute.sv
